//--- rtl/axil_pkg.sv
// AXI-Lite protocol definitions
`default_nettype none

package axil_pkg;

    localparam int RESP_W = 2;

    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    localparam int DEF_ADDR_W = 32;
    localparam int DEF_DATA_W = 32;

endpackage

`default_nettype wire

//--- rtl/xbar_map_pkg.sv
// Crossbar sizing and address map
`default_nettype none

package xbar_map_pkg;

    localparam int DEF_N_MASTERS = 2;
    localparam int DEF_N_SLAVES  = 3;

    // window 0 sits in the rightmost word
    localparam logic [DEF_N_SLAVES-1:0][31:0] DEF_SLAVE_LOW  =
        {32'h43C2_0000, 32'h43C1_0000, 32'h43C0_0000};
    localparam logic [DEF_N_SLAVES-1:0][31:0] DEF_SLAVE_HIGH =
        {32'h43C2_FFFF, 32'h43C1_FFFF, 32'h43C0_FFFF};

    function automatic int sel_w(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

endpackage

`default_nettype wire

//--- rtl/xbar_rr_arbiter.sv
// Round-robin manager arbiter
`timescale 1ns/1ns
`default_nettype none

module xbar_rr_arbiter #(
    parameter int N_MASTERS = 2
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic [N_MASTERS-1:0] req_i,
    input  logic                 take_i,
    output logic [N_MASTERS-1:0] grant_o
);
    import xbar_map_pkg::*;

    localparam int PTR_W = sel_w(N_MASTERS);

    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] win_idx;

    always_comb begin
        int   cand;
        logic found;
        cand    = 0;
        found   = 1'b0;
        grant_o = '0;
        win_idx = ptr_q;
        for (int i = 0; i < N_MASTERS; i++) begin
            cand = (int'(ptr_q) + i) % N_MASTERS; // search upward from the pointer
            if (!found && req_i[cand]) begin
                found         = 1'b1;
                grant_o[cand] = 1'b1;
                win_idx       = PTR_W'(cand);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ptr_q <= '0;
        end else if (take_i) begin
            ptr_q <= PTR_W'((int'(win_idx) + 1) % N_MASTERS); // one past the winner
        end
    end

endmodule

`default_nettype wire

//--- rtl/xbar_addr_decoder.sv
// Subordinate address decoder
`timescale 1ns/1ns
`default_nettype none

module xbar_addr_decoder #(
    parameter int ADDR_W   = 32,
    parameter int N_SLAVES = 3,
    parameter logic [N_SLAVES-1:0][ADDR_W-1:0] SLAVE_LOW  = xbar_map_pkg::DEF_SLAVE_LOW,
    parameter logic [N_SLAVES-1:0][ADDR_W-1:0] SLAVE_HIGH = xbar_map_pkg::DEF_SLAVE_HIGH
) (
    input  logic [ADDR_W-1:0]                        addr_i,
    output logic [xbar_map_pkg::sel_w(N_SLAVES)-1:0] idx_o,
    output logic                                     hit_o
);
    import xbar_map_pkg::*;

    localparam int SEL_W = sel_w(N_SLAVES);

    always_comb begin
        idx_o = '0;
        hit_o = 1'b0;
        for (int i = N_SLAVES - 1; i >= 0; i--) begin // downward scan leaves the lowest match
            if (addr_i >= SLAVE_LOW[i] && addr_i <= SLAVE_HIGH[i]) begin
                idx_o = SEL_W'(i);
                hit_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/xbar_write_path.sv
// Crossbar write path
`timescale 1ns/1ns
`default_nettype none

module xbar_write_path #(
    parameter int ADDR_W    = 32,
    parameter int DATA_W    = 32,
    parameter int N_MASTERS = 2,
    parameter int N_SLAVES  = 3
) (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic [N_MASTERS-1:0][ADDR_W-1:0]            s_awaddr_i,
    input  logic [N_MASTERS-1:0]                        s_awvalid_i,
    output logic [N_MASTERS-1:0]                        s_awready_o,
    input  logic [N_MASTERS-1:0][DATA_W-1:0]            s_wdata_i,
    input  logic [N_MASTERS-1:0][DATA_W/8-1:0]          s_wstrb_i,
    input  logic [N_MASTERS-1:0]                        s_wvalid_i,
    output logic [N_MASTERS-1:0]                        s_wready_o,
    output logic [N_MASTERS-1:0][axil_pkg::RESP_W-1:0]  s_bresp_o,
    output logic [N_MASTERS-1:0]                        s_bvalid_o,
    input  logic [N_MASTERS-1:0]                        s_bready_i,
    output logic [N_SLAVES-1:0][ADDR_W-1:0]             m_awaddr_o,
    output logic [N_SLAVES-1:0]                         m_awvalid_o,
    input  logic [N_SLAVES-1:0]                         m_awready_i,
    output logic [N_SLAVES-1:0][DATA_W-1:0]             m_wdata_o,
    output logic [N_SLAVES-1:0][DATA_W/8-1:0]           m_wstrb_o,
    output logic [N_SLAVES-1:0]                         m_wvalid_o,
    input  logic [N_SLAVES-1:0]                         m_wready_i,
    input  logic [N_SLAVES-1:0][axil_pkg::RESP_W-1:0]   m_bresp_i,
    input  logic [N_SLAVES-1:0]                         m_bvalid_i,
    output logic [N_SLAVES-1:0]                         m_bready_o,
    output logic [N_MASTERS-1:0]                        req_o,
    output logic                                        take_o,
    input  logic [N_MASTERS-1:0]                        grant_i,
    output logic [ADDR_W-1:0]                           dec_addr_o,
    input  logic [xbar_map_pkg::sel_w(N_SLAVES)-1:0]    dec_idx_i,
    input  logic                                        dec_hit_i
);
    import axil_pkg::*;
    import xbar_map_pkg::*;

    localparam int MST_W = sel_w(N_MASTERS);
    localparam int SLV_W = sel_w(N_SLAVES);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e        state_q;
    wr_state_e        state_d;
    logic [MST_W-1:0] gnt_idx;
    logic [MST_W-1:0] mst_q;
    logic [SLV_W-1:0] slv_q;
    logic             hit_q;
    logic             aw_done;
    logic             w_done;
    logic             b_done;

    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant_i[i]) begin
                gnt_idx = MST_W'(i);
            end
        end
    end

    assign req_o      = s_awvalid_i;
    assign take_o     = (state_q == WR_IDLE) && (|grant_i);
    assign dec_addr_o = s_awaddr_i[gnt_idx];

    // on a miss the crossbar itself acts as the subordinate
    assign aw_done = s_awvalid_i[mst_q] && (!hit_q || m_awready_i[slv_q]);
    assign w_done  = s_wvalid_i[mst_q] && (!hit_q || m_wready_i[slv_q]);
    assign b_done  = s_bready_i[mst_q] && (!hit_q || m_bvalid_i[slv_q]);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= WR_IDLE;
            mst_q   <= '0;
            slv_q   <= '0;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_o) begin
                mst_q <= gnt_idx;
                slv_q <= dec_idx_i;
                hit_q <= dec_hit_i;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: if (take_o) state_d = WR_ADDR;
            WR_ADDR: if (aw_done) state_d = WR_DATA;
            WR_DATA: if (w_done) state_d = WR_RESP;
            WR_RESP: if (b_done) state_d = WR_IDLE;
            default: state_d = WR_IDLE;
        endcase
    end

    always_comb begin
        m_awaddr_o  = '0;
        m_awvalid_o = '0;
        m_wdata_o   = '0;
        m_wstrb_o   = '0;
        m_wvalid_o  = '0;
        m_bready_o  = '0;
        s_awready_o = '0;
        s_wready_o  = '0;
        s_bresp_o   = '0;
        s_bvalid_o  = '0;
        case (state_q)
            WR_ADDR: begin
                s_awready_o[mst_q] = hit_q ? m_awready_i[slv_q] : 1'b1;
                if (hit_q) begin
                    m_awaddr_o[slv_q]  = s_awaddr_i[mst_q];
                    m_awvalid_o[slv_q] = s_awvalid_i[mst_q];
                end
            end
            WR_DATA: begin
                s_wready_o[mst_q] = hit_q ? m_wready_i[slv_q] : 1'b1; // miss drops the data
                if (hit_q) begin
                    m_wdata_o[slv_q]  = s_wdata_i[mst_q];
                    m_wstrb_o[slv_q]  = s_wstrb_i[mst_q];
                    m_wvalid_o[slv_q] = s_wvalid_i[mst_q];
                end
            end
            WR_RESP: begin
                s_bvalid_o[mst_q] = hit_q ? m_bvalid_i[slv_q] : 1'b1;
                s_bresp_o[mst_q]  = hit_q ? m_bresp_i[slv_q] : RESP_DECERR;
                if (hit_q) begin
                    m_bready_o[slv_q] = s_bready_i[mst_q];
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/xbar_read_path.sv
// Crossbar read path
`timescale 1ns/1ns
`default_nettype none

module xbar_read_path #(
    parameter int ADDR_W    = 32,
    parameter int DATA_W    = 32,
    parameter int N_MASTERS = 2,
    parameter int N_SLAVES  = 3
) (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic [N_MASTERS-1:0][ADDR_W-1:0]            s_araddr_i,
    input  logic [N_MASTERS-1:0]                        s_arvalid_i,
    output logic [N_MASTERS-1:0]                        s_arready_o,
    output logic [N_MASTERS-1:0][DATA_W-1:0]            s_rdata_o,
    output logic [N_MASTERS-1:0][axil_pkg::RESP_W-1:0]  s_rresp_o,
    output logic [N_MASTERS-1:0]                        s_rvalid_o,
    input  logic [N_MASTERS-1:0]                        s_rready_i,
    output logic [N_SLAVES-1:0][ADDR_W-1:0]             m_araddr_o,
    output logic [N_SLAVES-1:0]                         m_arvalid_o,
    input  logic [N_SLAVES-1:0]                         m_arready_i,
    input  logic [N_SLAVES-1:0][DATA_W-1:0]             m_rdata_i,
    input  logic [N_SLAVES-1:0][axil_pkg::RESP_W-1:0]   m_rresp_i,
    input  logic [N_SLAVES-1:0]                         m_rvalid_i,
    output logic [N_SLAVES-1:0]                         m_rready_o,
    output logic [N_MASTERS-1:0]                        req_o,
    output logic                                        take_o,
    input  logic [N_MASTERS-1:0]                        grant_i,
    output logic [ADDR_W-1:0]                           dec_addr_o,
    input  logic [xbar_map_pkg::sel_w(N_SLAVES)-1:0]    dec_idx_i,
    input  logic                                        dec_hit_i
);
    import axil_pkg::*;
    import xbar_map_pkg::*;

    localparam int MST_W = sel_w(N_MASTERS);
    localparam int SLV_W = sel_w(N_SLAVES);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e        state_q;
    rd_state_e        state_d;
    logic [MST_W-1:0] gnt_idx;
    logic [MST_W-1:0] mst_q;
    logic [SLV_W-1:0] slv_q;
    logic             hit_q;
    logic             ar_done;
    logic             r_done;

    always_comb begin
        gnt_idx = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant_i[i]) begin
                gnt_idx = MST_W'(i);
            end
        end
    end

    assign req_o      = s_arvalid_i;
    assign take_o     = (state_q == RD_IDLE) && (|grant_i);
    assign dec_addr_o = s_araddr_i[gnt_idx];

    assign ar_done = s_arvalid_i[mst_q] && (!hit_q || m_arready_i[slv_q]);
    assign r_done  = s_rready_i[mst_q] && (!hit_q || m_rvalid_i[slv_q]);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RD_IDLE;
            mst_q   <= '0;
            slv_q   <= '0;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_o) begin
                mst_q <= gnt_idx;
                slv_q <= dec_idx_i;
                hit_q <= dec_hit_i;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: if (take_o) state_d = RD_ADDR;
            RD_ADDR: if (ar_done) state_d = RD_DATA;
            RD_DATA: if (r_done) state_d = RD_IDLE;
            default: state_d = RD_IDLE;
        endcase
    end

    always_comb begin
        m_araddr_o  = '0;
        m_arvalid_o = '0;
        m_rready_o  = '0;
        s_arready_o = '0;
        s_rdata_o   = '0;
        s_rresp_o   = '0;
        s_rvalid_o  = '0;
        case (state_q)
            RD_ADDR: begin
                s_arready_o[mst_q] = hit_q ? m_arready_i[slv_q] : 1'b1;
                if (hit_q) begin
                    m_araddr_o[slv_q]  = s_araddr_i[mst_q];
                    m_arvalid_o[slv_q] = s_arvalid_i[mst_q];
                end
            end
            RD_DATA: begin
                s_rvalid_o[mst_q] = hit_q ? m_rvalid_i[slv_q] : 1'b1;
                s_rresp_o[mst_q]  = hit_q ? m_rresp_i[slv_q] : RESP_DECERR;
                s_rdata_o[mst_q]  = hit_q ? m_rdata_i[slv_q] : '0; // zero data on a miss
                if (hit_q) begin
                    m_rready_o[slv_q] = s_rready_i[mst_q];
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/axil_xbar_top.sv
// AXI-Lite crossbar top
`timescale 1ns/1ns
`default_nettype none

module axil_xbar_top #(
    parameter int ADDR_W    = axil_pkg::DEF_ADDR_W,
    parameter int DATA_W    = axil_pkg::DEF_DATA_W,
    parameter int N_MASTERS = xbar_map_pkg::DEF_N_MASTERS,
    parameter int N_SLAVES  = xbar_map_pkg::DEF_N_SLAVES,
    parameter logic [N_SLAVES-1:0][ADDR_W-1:0] SLAVE_LOW  = xbar_map_pkg::DEF_SLAVE_LOW,
    parameter logic [N_SLAVES-1:0][ADDR_W-1:0] SLAVE_HIGH = xbar_map_pkg::DEF_SLAVE_HIGH
) (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    // manager side
    input  logic [N_MASTERS-1:0][ADDR_W-1:0]            s_awaddr_i,
    input  logic [N_MASTERS-1:0]                        s_awvalid_i,
    output logic [N_MASTERS-1:0]                        s_awready_o,
    input  logic [N_MASTERS-1:0][DATA_W-1:0]            s_wdata_i,
    input  logic [N_MASTERS-1:0][DATA_W/8-1:0]          s_wstrb_i,
    input  logic [N_MASTERS-1:0]                        s_wvalid_i,
    output logic [N_MASTERS-1:0]                        s_wready_o,
    output logic [N_MASTERS-1:0][axil_pkg::RESP_W-1:0]  s_bresp_o,
    output logic [N_MASTERS-1:0]                        s_bvalid_o,
    input  logic [N_MASTERS-1:0]                        s_bready_i,
    input  logic [N_MASTERS-1:0][ADDR_W-1:0]            s_araddr_i,
    input  logic [N_MASTERS-1:0]                        s_arvalid_i,
    output logic [N_MASTERS-1:0]                        s_arready_o,
    output logic [N_MASTERS-1:0][DATA_W-1:0]            s_rdata_o,
    output logic [N_MASTERS-1:0][axil_pkg::RESP_W-1:0]  s_rresp_o,
    output logic [N_MASTERS-1:0]                        s_rvalid_o,
    input  logic [N_MASTERS-1:0]                        s_rready_i,
    // subordinate side
    output logic [N_SLAVES-1:0][ADDR_W-1:0]             m_awaddr_o,
    output logic [N_SLAVES-1:0]                         m_awvalid_o,
    input  logic [N_SLAVES-1:0]                         m_awready_i,
    output logic [N_SLAVES-1:0][DATA_W-1:0]             m_wdata_o,
    output logic [N_SLAVES-1:0][DATA_W/8-1:0]           m_wstrb_o,
    output logic [N_SLAVES-1:0]                         m_wvalid_o,
    input  logic [N_SLAVES-1:0]                         m_wready_i,
    input  logic [N_SLAVES-1:0][axil_pkg::RESP_W-1:0]   m_bresp_i,
    input  logic [N_SLAVES-1:0]                         m_bvalid_i,
    output logic [N_SLAVES-1:0]                         m_bready_o,
    output logic [N_SLAVES-1:0][ADDR_W-1:0]             m_araddr_o,
    output logic [N_SLAVES-1:0]                         m_arvalid_o,
    input  logic [N_SLAVES-1:0]                         m_arready_i,
    input  logic [N_SLAVES-1:0][DATA_W-1:0]             m_rdata_i,
    input  logic [N_SLAVES-1:0][axil_pkg::RESP_W-1:0]   m_rresp_i,
    input  logic [N_SLAVES-1:0]                         m_rvalid_i,
    output logic [N_SLAVES-1:0]                         m_rready_o
);
    import xbar_map_pkg::*;

    localparam int SLV_W = sel_w(N_SLAVES);

    logic [N_MASTERS-1:0] wr_req;
    logic                 wr_take;
    logic [N_MASTERS-1:0] wr_grant;
    logic [ADDR_W-1:0]    wr_dec_addr;
    logic [SLV_W-1:0]     wr_dec_idx;
    logic                 wr_dec_hit;
    logic [N_MASTERS-1:0] rd_req;
    logic                 rd_take;
    logic [N_MASTERS-1:0] rd_grant;
    logic [ADDR_W-1:0]    rd_dec_addr;
    logic [SLV_W-1:0]     rd_dec_idx;
    logic                 rd_dec_hit;

    // channel ports share their names with the top ports
    xbar_write_path #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W), .N_MASTERS(N_MASTERS), .N_SLAVES(N_SLAVES)
    ) i_write_path (
        .req_o     (wr_req),
        .take_o    (wr_take),
        .grant_i   (wr_grant),
        .dec_addr_o(wr_dec_addr),
        .dec_idx_i (wr_dec_idx),
        .dec_hit_i (wr_dec_hit),
        .*
    );

    xbar_read_path #(
        .ADDR_W(ADDR_W), .DATA_W(DATA_W), .N_MASTERS(N_MASTERS), .N_SLAVES(N_SLAVES)
    ) i_read_path (
        .req_o     (rd_req),
        .take_o    (rd_take),
        .grant_i   (rd_grant),
        .dec_addr_o(rd_dec_addr),
        .dec_idx_i (rd_dec_idx),
        .dec_hit_i (rd_dec_hit),
        .*
    );

    xbar_rr_arbiter #(.N_MASTERS(N_MASTERS)) i_wr_arbiter (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (wr_req),
        .take_i (wr_take),
        .grant_o(wr_grant)
    );

    xbar_rr_arbiter #(.N_MASTERS(N_MASTERS)) i_rd_arbiter (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (rd_req),
        .take_i (rd_take),
        .grant_o(rd_grant)
    );

    xbar_addr_decoder #(
        .ADDR_W(ADDR_W), .N_SLAVES(N_SLAVES), .SLAVE_LOW(SLAVE_LOW), .SLAVE_HIGH(SLAVE_HIGH)
    ) i_wr_decoder (
        .addr_i(wr_dec_addr),
        .idx_o (wr_dec_idx),
        .hit_o (wr_dec_hit)
    );

    xbar_addr_decoder #(
        .ADDR_W(ADDR_W), .N_SLAVES(N_SLAVES), .SLAVE_LOW(SLAVE_LOW), .SLAVE_HIGH(SLAVE_HIGH)
    ) i_rd_decoder (
        .addr_i(rd_dec_addr),
        .idx_o (rd_dec_idx),
        .hit_o (rd_dec_hit)
    );

endmodule

`default_nettype wire

//--- tests/axil_mem_slave.sv
// AXI-Lite memory model
`timescale 1ns/1ns
`default_nettype none

module axil_mem_slave (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [1:0]  delay_i,
    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i
);
    logic [31:0] mem [256];
    logic [7:0]  waddr_q;
    logic        aw_got_q;
    logic [1:0]  w_cnt_q;
    logic [1:0]  r_cnt_q;
    logic        w_waiting;
    logic        r_waiting;

    assign bresp_o   = 2'b00; // always OKAY
    assign rresp_o   = 2'b00;
    assign awready_o = awvalid_i && !aw_got_q && (w_cnt_q >= delay_i);
    assign wready_o  = wvalid_i && aw_got_q && !bvalid_o && (w_cnt_q >= delay_i);
    assign arready_o = arvalid_i && !rvalid_o && (r_cnt_q >= delay_i);
    assign w_waiting = (awvalid_i && !aw_got_q) || (wvalid_i && aw_got_q && !bvalid_o);
    assign r_waiting = arvalid_i && !rvalid_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            waddr_q  <= '0;
            aw_got_q <= 1'b0;
            w_cnt_q  <= '0;
            r_cnt_q  <= '0;
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            if (awready_o) begin
                aw_got_q <= 1'b1;
                waddr_q  <= awaddr_i[9:2]; // word offset
                w_cnt_q  <= '0;
            end else if (wready_o) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb_i[b]) mem[waddr_q][8*b +: 8] <= wdata_i[8*b +: 8];
                end
                aw_got_q <= 1'b0;
                bvalid_o <= 1'b1;
                w_cnt_q  <= '0;
            end else if (w_waiting && w_cnt_q != 2'd3) begin
                w_cnt_q <= w_cnt_q + 2'd1;
            end
            if (bvalid_o && bready_i) bvalid_o <= 1'b0;
            if (arready_o) begin
                rdata_o  <= mem[araddr_i[9:2]];
                rvalid_o <= 1'b1;
                r_cnt_q  <= '0;
            end else if (r_waiting && r_cnt_q != 2'd3) begin
                r_cnt_q <= r_cnt_q + 2'd1;
            end
            if (rvalid_o && rready_i) rvalid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_axil_xbar.sv
// AXI-Lite crossbar testbench
`timescale 1ns/1ns
`default_nettype none

module tb_axil_xbar;
    import xbar_map_pkg::*;

    localparam int NM = DEF_N_MASTERS;
    localparam int NS = DEF_N_SLAVES;
    localparam int MAX_LINES = 64;

    logic clk_i;
    logic rstn_i;
    logic [NM-1:0][31:0] s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o;
    logic [NM-1:0][3:0]  s_wstrb_i;
    logic [NM-1:0][1:0]  s_bresp_o, s_rresp_o;
    logic [NM-1:0] s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
    logic [NM-1:0] s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
    logic [NS-1:0][31:0] m_awaddr_o, m_wdata_o, m_araddr_o, m_rdata_i;
    logic [NS-1:0][3:0]  m_wstrb_o;
    logic [NS-1:0][1:0]  m_bresp_i, m_rresp_i, delay;
    logic [NS-1:0] m_awvalid_o, m_awready_i, m_wvalid_o, m_wready_i, m_bvalid_i, m_bready_o;
    logic [NS-1:0] m_arvalid_o, m_arready_i, m_rvalid_i, m_rready_o;

    int          t_grp [MAX_LINES];
    int          t_mgr [MAX_LINES];
    logic        t_wr [MAX_LINES];
    logic [31:0] t_addr [MAX_LINES], t_data [MAX_LINES], t_strb [MAX_LINES];
    logic [31:0] t_resp [MAX_LINES], t_rdata [MAX_LINES];
    int          nlines = 0;
    int          cycles = 0;
    int          limit = 0;
    int          done_at [NM];
    int          wr_ptr = 0;
    int          rd_ptr = 0;
    logic [31:0] seed = 32'd39;

    axil_xbar_top i_dut (.*);

    for (genvar g = 0; g < NS; g++) begin : g_mem
        axil_mem_slave i_mem (
            .clk_i(clk_i), .rstn_i(rstn_i), .delay_i(delay[g]),
            .awaddr_i(m_awaddr_o[g]), .awvalid_i(m_awvalid_o[g]), .awready_o(m_awready_i[g]),
            .wdata_i(m_wdata_o[g]), .wstrb_i(m_wstrb_o[g]), .wvalid_i(m_wvalid_o[g]),
            .wready_o(m_wready_i[g]), .bresp_o(m_bresp_i[g]), .bvalid_o(m_bvalid_i[g]),
            .bready_i(m_bready_o[g]), .araddr_i(m_araddr_o[g]), .arvalid_i(m_arvalid_o[g]),
            .arready_o(m_arready_i[g]), .rdata_o(m_rdata_i[g]), .rresp_o(m_rresp_i[g]),
            .rvalid_o(m_rvalid_i[g]), .rready_i(m_rready_o[g])
        );
    end

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always @(negedge clk_i) begin // fresh ready delays every cycle
        for (int s = 0; s < NS; s++) begin
            seed = lcg_next(seed);
            delay[s] = seed[17:16];
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, a transaction never completed", cycles);
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic ready_now(input int ch, input int m);
        case (ch)
            0: return s_awready_o[m];
            1: return s_wready_o[m];
            2: return s_bvalid_o[m];
            3: return s_arready_o[m];
            default: return s_rvalid_o[m];
        endcase
    endfunction

    // ready is stable between the falling edge and the next rising edge
    task automatic wait_ready(input int ch, input int m);
        #2;
        while (!ready_now(ch, m)) begin
            @(negedge clk_i);
            #2;
        end
    endtask

    task automatic run_txn(input int k);
        int m;
        m = t_mgr[k];
        @(negedge clk_i);
        if (t_wr[k]) begin
            s_awaddr_i[m] = t_addr[k];
            s_awvalid_i[m] = 1'b1;
            wait_ready(0, m);
            @(negedge clk_i);
            s_awvalid_i[m] = 1'b0;
            s_wdata_i[m] = t_data[k];
            s_wstrb_i[m] = t_strb[k][3:0];
            s_wvalid_i[m] = 1'b1;
            wait_ready(1, m);
            @(negedge clk_i);
            s_wvalid_i[m] = 1'b0;
            s_bready_i[m] = 1'b1;
            wait_ready(2, m);
            done_at[m] = cycles;
            check_val("s_bresp_o", 32'(s_bresp_o[m]), t_resp[k]);
            @(negedge clk_i);
            s_bready_i[m] = 1'b0;
        end else begin
            s_araddr_i[m] = t_addr[k];
            s_arvalid_i[m] = 1'b1;
            wait_ready(3, m);
            @(negedge clk_i);
            s_arvalid_i[m] = 1'b0;
            s_rready_i[m] = 1'b1;
            wait_ready(4, m);
            done_at[m] = cycles;
            check_val("s_rresp_o", 32'(s_rresp_o[m]), t_resp[k]);
            check_val("s_rdata_o", s_rdata_o[m], t_rdata[k]);
            @(negedge clk_i);
            s_rready_i[m] = 1'b0;
        end
    endtask

    task automatic update_ptr(input int k);
        if (t_wr[k]) wr_ptr = (t_mgr[k] + 1) % NM;
        else rd_ptr = (t_mgr[k] + 1) % NM;
    endtask

    initial begin
        int fd, n, k, g, mm, first, exp_first;
        string line, op;
        logic [31:0] a, d, s, r, x;
        {s_awaddr_i, s_awvalid_i, s_wdata_i, s_wstrb_i, s_wvalid_i, s_bready_i} = '0;
        {s_araddr_i, s_arvalid_i, s_rready_i} = '0;
        delay = '0;
        rstn_i = 1'b0;
        fd = $fopen("tests/xbar_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("Something failed");
            $fatal(1);
        end
        while (!$feof(fd) && nlines < MAX_LINES) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %s %h %h %h %h %h", g, mm, op, a, d, s, r, x);
                if (n == 8) begin
                    t_grp[nlines] = g;
                    t_mgr[nlines] = mm;
                    t_wr[nlines] = (op == "W");
                    t_addr[nlines] = a;
                    t_data[nlines] = d;
                    t_strb[nlines] = s;
                    t_resp[nlines] = r;
                    t_rdata[nlines] = x;
                    nlines++;
                end
            end
        end
        $fclose(fd);
        limit = 40 * nlines + 100;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        k = 0;
        while (k < nlines) begin
            if (k + 1 < nlines && t_grp[k + 1] == t_grp[k]) begin
                fork
                    run_txn(k);
                    run_txn(k + 1);
                join
                if (t_wr[k] == t_wr[k + 1]) begin
                    exp_first = t_wr[k] ? wr_ptr : rd_ptr; // pointer is back where it was
                    first = (done_at[0] < done_at[1]) ? 0 : 1;
                    check_val("first_mgr", 32'(first), 32'(exp_first));
                end else begin
                    update_ptr(k);
                    update_ptr(k + 1);
                end
                k += 2;
            end else begin
                run_txn(k);
                update_ptr(k);
                k++;
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/xbar_stimulus.txt
# group mgr op(W/R) addr(hex) data(hex) strb(hex) exp_resp(hex) exp_rdata(hex)
# lines sharing a group start on both managers together
1 0 W 43C00010 11111111 F 0 00000000
1 1 W 43C10020 22222222 F 0 00000000
2 0 W 43C20030 33333333 F 0 00000000
2 1 W 43C00040 44444444 F 0 00000000
3 0 R 43C00010 00000000 0 0 11111111
4 1 R 43C10020 00000000 0 0 22222222
5 0 R 43C20030 00000000 0 0 33333333
5 1 R 43C00040 00000000 0 0 44444444
6 1 W 43C10020 AABBCCDD 5 0 00000000
7 0 R 43C10020 00000000 0 0 22BB22DD
8 0 W 50000000 DEADBEEF F 3 00000000
9 1 R 50000000 00000000 0 3 00000000
10 0 W 43C30000 01020304 F 3 00000000
11 1 R 43C00010 00000000 0 0 11111111
12 0 W 43C2FFFC CAFEF00D F 0 00000000
12 1 R 43C20030 00000000 0 0 33333333
13 1 R 43C2FFFC 00000000 0 0 CAFEF00D
13 0 W 43C0FFFC 0BADC0DE F 0 00000000
14 0 R 43C0FFFC 00000000 0 0 0BADC0DE
14 1 W 43C00010 55667788 C 0 00000000
15 0 R 43C00010 00000000 0 0 55661111
15 1 R 43C10020 00000000 0 0 22BB22DD

//--- sources.f
rtl/axil_pkg.sv
rtl/xbar_map_pkg.sv
rtl/xbar_rr_arbiter.sv
rtl/xbar_addr_decoder.sv
rtl/xbar_write_path.sv
rtl/xbar_read_path.sv
rtl/axil_xbar_top.sv
tests/axil_mem_slave.sv
tests/tb_axil_xbar.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line
verilator --binary -f sources.f --top-module tb_axil_xbar -o tb_axil_xbar \
    && ./obj_dir/tb_axil_xbar | grep "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
